/* hw/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry shared by the package and the RTL

// ways searched in parallel on every lookup
`define ICACHE_WAYS 4

// sets per way and the index that selects one
`define ICACHE_SETS 128
`define ICACHE_SET_BITS 7

// chunk index inside a line, one flag bit per chunk
`define ICACHE_CHUNK_BITS 4

// remaining fetch address bits above set and chunk
`define ICACHE_TAG_BITS 19

// payload of one line
`define ICACHE_LINE_BITS 128

`endif

/* hw/icache_pkg.sv */
`include "icache_consts.svh"

package icache_pkg;

  typedef logic [`ICACHE_SET_BITS-1:0] set_idx_t;

  typedef logic [`ICACHE_WAYS-1:0] way_vec_t; // one-hot select or per-way mask

  typedef logic [`ICACHE_LINE_BITS-1:0] line_t;

  typedef logic [(1 << `ICACHE_CHUNK_BITS)-1:0] flags_t; // executed bit per chunk

  // fetch address as seen by the cache with the chunk in the low bits
  typedef struct packed {
    logic [`ICACHE_TAG_BITS-1:0]   tag;
    set_idx_t                      set;
    logic [`ICACHE_CHUNK_BITS-1:0] chunk;
  } fetch_addr_t;

  typedef struct packed {
    logic                        valid;
    logic [`ICACHE_TAG_BITS-1:0] tag;
  } tag_entry_t;

endpackage

/* hw/cc_if.sv */
`include "icache_consts.svh"

// lookup result with one strobe per fetch that made it past the sweep
interface cc_hit_if import icache_pkg::*; ();
  logic                          hit_valid;
  way_vec_t                      hit_way; // zero on a miss
  set_idx_t                      hit_set;
  logic [`ICACHE_CHUNK_BITS-1:0] hit_chunk;
  logic                          hit_set_flag;

  modport producer (output hit_valid, hit_way, hit_set, hit_chunk, hit_set_flag);
  modport consumer (input hit_valid, hit_way, hit_set, hit_chunk, hit_set_flag);
endinterface

// line write that lands at the edge ending the strobe cycle
interface cc_fill_if import icache_pkg::*; ();
  logic     fill_en;
  set_idx_t fill_set;
  way_vec_t fill_way;
  line_t    fill_data;

  modport producer (output fill_en, fill_set, fill_way, fill_data);
  modport consumer (input fill_en, fill_set, fill_way, fill_data);
endinterface

/* hw/cc_ram.sv */
`include "icache_consts.svh"

module cc_ram import icache_pkg::*; #(
  parameter type payload_t = line_t
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     rd_en,
  input  set_idx_t rd_addr,
  output payload_t rd_data,
  input  logic     wr_en,
  input  set_idx_t wr_addr,
  input  payload_t wr_data
);

  payload_t mem [`ICACHE_SETS];
  set_idx_t rd_addr_q;

  assign rd_data = mem[rd_addr_q]; // a write on the loading edge is already visible

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

/* hw/cc_tag_way.sv */
`include "icache_consts.svh"

module cc_tag_way import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        look_en,
  input  fetch_addr_t look_addr,
  output logic        look_hit,
  input  logic        chk_en,
  input  fetch_addr_t chk_addr,
  output logic        chk_hit,
  output tag_entry_t  chk_entry,
  input  logic        wr_en,
  input  set_idx_t    wr_set,
  input  tag_entry_t  wr_entry
);

  tag_entry_t                  look_entry;
  logic [`ICACHE_TAG_BITS-1:0] look_tag_q;
  logic [`ICACHE_TAG_BITS-1:0] chk_tag_q;

  // both copies take every write, so the fill check never steals a fetch slot
  cc_ram #(.payload_t(tag_entry_t)) i_look_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (look_en),
    .rd_addr (look_addr.set),
    .rd_data (look_entry),
    .wr_en   (wr_en),
    .wr_addr (wr_set),
    .wr_data (wr_entry)
  );

  cc_ram #(.payload_t(tag_entry_t)) i_chk_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (chk_en),
    .rd_addr (chk_addr.set),
    .rd_data (chk_entry),
    .wr_en   (wr_en),
    .wr_addr (wr_set),
    .wr_data (wr_entry)
  );

  always_ff @(posedge clk) begin
    if (look_en) begin
      look_tag_q <= look_addr.tag;
    end
    if (chk_en) begin
      chk_tag_q <= chk_addr.tag;
    end
  end

  assign look_hit = look_entry.valid && (look_entry.tag == look_tag_q);
  assign chk_hit  = chk_entry.valid && (chk_entry.tag == chk_tag_q);

endmodule

/* hw/cc_lookup.sv */
`include "icache_consts.svh"

module cc_lookup import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_en,
  input  fetch_addr_t rd_addr,
  input  logic        rd_set_flag,
  input  logic        wr_en,
  input  fetch_addr_t wr_addr,
  input  line_t       wr_data,
  output logic        init_busy,
  output logic        evict_en,
  output fetch_addr_t evict_addr,
  cc_hit_if.producer  hit,
  cc_fill_if.producer fill
);

  logic                          rd_go;
  logic                          wr_go;
  set_idx_t                      init_cnt;
  logic                          rd_q;
  set_idx_t                      rd_set_q;
  logic [`ICACHE_CHUNK_BITS-1:0] rd_chunk_q;
  logic                          rd_flag_q;
  logic                          wr_q;
  set_idx_t                      wr_set_q;
  logic [`ICACHE_TAG_BITS-1:0]   wr_tag_q;
  line_t                         wr_data_q;
  way_vec_t                      look_hit;
  way_vec_t                      chk_hit;
  way_vec_t                      valid_vec;
  tag_entry_t                    chk_entry [`ICACHE_WAYS];
  tag_entry_t                    victim_entry;
  way_vec_t                      victim;
  way_vec_t                      nru_q [`ICACHE_SETS];
  logic                          nru_upd;
  set_idx_t                      nru_set;
  way_vec_t                      nru_cur;
  way_vec_t                      nru_way;
  way_vec_t                      nru_next;
  logic [`ICACHE_TAG_BITS-1:0]   fill_tag_q;
  logic                          evict_pend_q;
  logic [`ICACHE_TAG_BITS-1:0]   evict_tag_q;
  set_idx_t                      tag_wr_set;
  tag_entry_t                    tag_wr_entry;

  function automatic way_vec_t low_one(way_vec_t v);
    return v & (~v + 1'b1);
  endfunction

  assign rd_go = rd_en & ~init_busy; // requests during the sweep are dropped
  assign wr_go = wr_en & ~init_busy;

  assign tag_wr_set   = init_busy ? init_cnt : fill.fill_set;
  assign tag_wr_entry = init_busy ? '0 : {1'b1, fill_tag_q};

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    cc_tag_way i_tag_way (
      .clk       (clk),
      .rst       (rst),
      .look_en   (rd_go),
      .look_addr (rd_addr),
      .look_hit  (look_hit[w]),
      .chk_en    (wr_go),
      .chk_addr  (wr_addr),
      .chk_hit   (chk_hit[w]),
      .chk_entry (chk_entry[w]),
      .wr_en     (init_busy | (fill.fill_en & fill.fill_way[w])),
      .wr_set    (tag_wr_set),
      .wr_entry  (tag_wr_entry)
    );
    assign valid_vec[w] = chk_entry[w].valid;
  end

  // rd and wr never share a cycle, so one NRU update port serves both
  assign nru_upd = (rd_q & (|look_hit)) | wr_q;
  assign nru_set = wr_q ? wr_set_q : rd_set_q;
  assign nru_cur = nru_q[nru_set];

  always_comb begin
    if (|chk_hit) begin
      victim = low_one(chk_hit); // refill of a resident line stays in place
    end else if (!(&valid_vec)) begin
      victim = low_one(~valid_vec);
    end else begin
      victim = low_one(~nru_cur);
    end
    nru_way  = wr_q ? victim : look_hit;
    nru_next = nru_cur | nru_way;
    if (&nru_next) begin
      nru_next = nru_way; // a saturated set starts a new round
    end
    victim_entry = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (victim[w]) begin
        victim_entry = chk_entry[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b1;
      init_cnt  <= '0;
    end else if (init_busy) begin
      init_cnt <= init_cnt + 1'b1;
      if (&init_cnt) begin
        init_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        nru_q[s] <= '0;
      end
    end else if (nru_upd) begin
      nru_q[nru_set] <= nru_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q          <= 1'b0;
      wr_q          <= 1'b0;
      hit.hit_valid <= 1'b0;
      fill.fill_en  <= 1'b0;
      evict_en      <= 1'b0;
    end else begin
      rd_q          <= rd_go;
      wr_q          <= wr_go;
      hit.hit_valid <= rd_q;
      fill.fill_en  <= wr_q;
      evict_en      <= fill.fill_en & evict_pend_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      rd_set_q   <= rd_addr.set;
      rd_chunk_q <= rd_addr.chunk;
      rd_flag_q  <= rd_set_flag;
    end
    if (wr_go) begin
      wr_set_q  <= wr_addr.set;
      wr_tag_q  <= wr_addr.tag;
      wr_data_q <= wr_data;
    end
    hit.hit_way      <= look_hit;
    hit.hit_set      <= rd_set_q;
    hit.hit_chunk    <= rd_chunk_q;
    hit.hit_set_flag <= rd_flag_q;
    fill.fill_set    <= wr_set_q;
    fill.fill_way    <= victim;
    fill.fill_data   <= wr_data_q;
    fill_tag_q       <= wr_tag_q;
    evict_pend_q     <= ~(|chk_hit) & victim_entry.valid;
    evict_tag_q      <= victim_entry.tag;
    evict_addr       <= {evict_tag_q, fill.fill_set, {`ICACHE_CHUNK_BITS{1'b0}}};
  end

endmodule

/* hw/cc_line_store.sv */
`include "icache_consts.svh"

module cc_line_store import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_en,
  input  fetch_addr_t rd_addr,
  cc_hit_if.consumer  hit,
  cc_fill_if.consumer fill,
  output line_t       way_lines [`ICACHE_WAYS],
  output flags_t      way_flags [`ICACHE_WAYS]
);

  logic     rd_q;
  set_idx_t rd_set_q;
  logic     flag_wr;
  flags_t   chunk_bit;
  line_t    ram_lines [`ICACHE_WAYS];
  flags_t   ram_flags [`ICACHE_WAYS];
  flags_t   flag_upd [`ICACHE_WAYS];

  assign flag_wr   = hit.hit_valid & hit.hit_set_flag;
  assign chunk_bit = flags_t'(1) << hit.hit_chunk;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_set_q <= rd_addr.set; // set of the read whose words arrive next cycle
    end
  end

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    logic fill_way_wr;
    logic byp_hit;

    assign fill_way_wr = fill.fill_en & fill.fill_way[w];
    assign flag_upd[w] = way_flags[w] | chunk_bit;
    // flag write still in flight for the set being read right behind it
    assign byp_hit = flag_wr & hit.hit_way[w] & (rd_set_q == hit.hit_set);

    cc_ram #(.payload_t(line_t)) i_data_ram (
      .clk     (clk),
      .rst     (rst),
      .rd_en   (rd_en),
      .rd_addr (rd_addr.set),
      .rd_data (ram_lines[w]),
      .wr_en   (fill_way_wr),
      .wr_addr (fill.fill_set),
      .wr_data (fill.fill_data)
    );

    cc_ram #(.payload_t(flags_t)) i_flag_ram (
      .clk     (clk),
      .rst     (rst),
      .rd_en   (rd_en),
      .rd_addr (rd_addr.set),
      .rd_data (ram_flags[w]),
      .wr_en   (fill_way_wr | (flag_wr & hit.hit_way[w])),
      .wr_addr (fill.fill_en ? fill.fill_set : hit.hit_set),
      .wr_data (fill.fill_en ? '0 : flag_upd[w]) // a new line starts with nothing executed
    );

    always_ff @(posedge clk) begin
      if (rd_q) begin
        way_lines[w] <= ram_lines[w];
        way_flags[w] <= byp_hit ? flag_upd[w] : ram_flags[w];
      end
    end
  end

endmodule

/* hw/cc_way_select.sv */
`include "icache_consts.svh"

module cc_way_select import icache_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  cc_hit_if.consumer hit,
  input  line_t      way_lines [`ICACHE_WAYS],
  input  flags_t     way_flags [`ICACHE_WAYS],
  output logic       rd_valid,
  output logic       rd_hit,
  output line_t      rd_data,
  output flags_t     rd_flags,
  output logic       rd_err
);

  line_t  sel_line;
  flags_t sel_flags;
  logic   multi_hit;

  always_comb begin
    sel_line  = '0;
    sel_flags = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (hit.hit_way[w]) begin
        sel_line  = sel_line | way_lines[w];
        sel_flags = sel_flags | way_flags[w];
      end
    end
  end

  assign multi_hit = |(hit.hit_way & (hit.hit_way - 1'b1)); // more than one bit set

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
      rd_hit   <= 1'b0;
      rd_err   <= 1'b0;
    end else begin
      rd_valid <= hit.hit_valid;
      rd_hit   <= hit.hit_valid & (|hit.hit_way);
      rd_err   <= hit.hit_valid & multi_hit;
    end
  end

  always_ff @(posedge clk) begin
    rd_data  <= sel_line;
    rd_flags <= sel_flags;
  end

endmodule

/* hw/icache_top.sv */
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_en,
  input  fetch_addr_t rd_addr,
  input  logic        rd_set_flag,
  output logic        rd_valid,
  output logic        rd_hit,
  output line_t       rd_data,
  output flags_t      rd_flags,
  output logic        rd_err,
  input  logic        wr_en,
  input  fetch_addr_t wr_addr,
  input  line_t       wr_data,
  output logic        init_busy,
  output logic        evict_en,
  output fetch_addr_t evict_addr
);

  line_t  way_lines [`ICACHE_WAYS];
  flags_t way_flags [`ICACHE_WAYS];

  cc_hit_if  i_hit_if ();
  cc_fill_if i_fill_if ();

  cc_lookup i_lookup (
    .clk         (clk),
    .rst         (rst),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_set_flag (rd_set_flag),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .init_busy   (init_busy),
    .evict_en    (evict_en),
    .evict_addr  (evict_addr),
    .hit         (i_hit_if),
    .fill        (i_fill_if)
  );

  // data and flags are addressed straight from the port, in step with the tags
  cc_line_store i_line_store (
    .clk       (clk),
    .rst       (rst),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .hit       (i_hit_if),
    .fill      (i_fill_if),
    .way_lines (way_lines),
    .way_flags (way_flags)
  );

  cc_way_select i_way_select (
    .clk       (clk),
    .rst       (rst),
    .hit       (i_hit_if),
    .way_lines (way_lines),
    .way_flags (way_flags),
    .rd_valid  (rd_valid),
    .rd_hit    (rd_hit),
    .rd_data   (rd_data),
    .rd_flags  (rd_flags),
    .rd_err    (rd_err)
  );

endmodule

/* sim/icache_checker.sv */
`include "icache_consts.svh"

module icache_checker import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_en,
  input  fetch_addr_t rd_addr,
  input  logic        rd_set_flag,
  input  logic        rd_valid,
  input  logic        rd_hit,
  input  line_t       rd_data,
  input  flags_t      rd_flags,
  input  logic        rd_err,
  input  logic        wr_en,
  input  fetch_addr_t wr_addr,
  input  line_t       wr_data,
  input  logic        init_busy,
  input  logic        evict_en,
  input  fetch_addr_t evict_addr,
  input  int          test_id,
  input  logic        test_done,
  output logic        idle,
  output int          err_count,
  output int          check_count
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic        is_fill;
    logic [31:0] due;
    fetch_addr_t addr;
    logic        flag;
    line_t       data;
  } req_t;

  typedef struct packed {
    logic [31:0] due;
    logic        hit;
    line_t       data;
    flags_t      flags;
  } rd_exp_t;

  typedef struct packed {
    logic [31:0] due;
    logic        en;
    fetch_addr_t addr;
  } ev_exp_t;

  req_t    req_q [$]; // requests waiting for the edge where the DUT applies them
  rd_exp_t rd_exp_q [$];
  ev_exp_t ev_exp_q [$];

  logic                        m_valid [`ICACHE_SETS][`ICACHE_WAYS];
  logic [`ICACHE_TAG_BITS-1:0] m_tag [`ICACHE_SETS][`ICACHE_WAYS];
  line_t                       m_line [`ICACHE_SETS][`ICACHE_WAYS];
  flags_t                      m_flags [`ICACHE_SETS][`ICACHE_WAYS];
  logic                        m_used [`ICACHE_SETS][`ICACHE_WAYS];

  int   cyc;
  int   busy_cycles;
  logic init_over;
  int   errs_before;
  int   checks_before;

  initial begin
    err_count     = 0;
    check_count   = 0;
    errs_before   = 0;
    checks_before = 0;
    idle          = 1'b1;
  end

  function automatic string test_name(input int id);
    case (id)
      1: return "init sweep";
      2: return "fill then read";
      3: return "flag update";
      4: return "victim choice";
      5: return "refill in place";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(input string what, input logic [127:0] got, input logic [127:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic fail_event(input string what);
    err_count++;
    $display("ERROR at %0d ns: %s", $time, what);
  endtask

  // mark a way used so that a full set starts a new round with only that way
  task automatic touch_way(input int s, input int w);
    logic all_used;
    m_used[s][w] = 1'b1;
    all_used = 1'b1;
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      all_used &= m_used[s][i];
    end
    if (all_used) begin
      for (int i = 0; i < `ICACHE_WAYS; i++) begin
        m_used[s][i] = (i == w);
      end
    end
  endtask

  task automatic apply_read(input req_t r);
    rd_exp_t e;
    int      s;
    int      hw;
    s  = r.addr.set;
    hw = -1;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == r.addr.tag) begin
        hw = w;
      end
    end
    e.due   = cyc + 1;
    e.hit   = (hw >= 0);
    e.data  = '0;
    e.flags = '0;
    if (hw >= 0) begin
      e.data  = m_line[s][hw];
      e.flags = m_flags[s][hw]; // value before this read's own update
      if (r.flag) begin
        m_flags[s][hw][r.addr.chunk] = 1'b1;
      end
      touch_way(s, hw);
    end
    rd_exp_q.push_back(e);
  endtask

  task automatic apply_fill(input req_t r);
    ev_exp_t e;
    int      s;
    int      v;
    s      = r.addr.set;
    v      = -1;
    e.en   = 1'b0;
    e.addr = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (v < 0 && m_valid[s][w] && m_tag[s][w] == r.addr.tag) begin
        v = w;
      end
    end
    if (v < 0) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (v < 0 && !m_valid[s][w]) begin
          v = w;
        end
      end
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (v < 0 && !m_used[s][w]) begin
          v = w;
        end
      end
      if (v < 0) begin
        v = 0;
      end
      if (m_valid[s][v]) begin
        e.en       = 1'b1;
        e.addr.tag = m_tag[s][v];
        e.addr.set = r.addr.set;
      end
    end
    e.due         = cyc + 1;
    m_valid[s][v] = 1'b1;
    m_tag[s][v]   = r.addr.tag;
    m_line[s][v]  = r.data;
    m_flags[s][v] = '0;
    touch_way(s, v);
    ev_exp_q.push_back(e);
  endtask

  task automatic check_outputs();
    rd_exp_t e;
    ev_exp_t f;
    if (rd_exp_q.size() > 0 && rd_exp_q[0].due == cyc) begin
      e = rd_exp_q.pop_front();
      if (rd_valid !== 1'b1) begin
        fail_event("rd_valid did not come two cycles after rd_en");
      end else begin
        compare("rd_hit", rd_hit, e.hit);
        compare("rd_err", rd_err, 1'b0);
        if (e.hit) begin
          compare("rd_data", rd_data, e.data);
          compare("rd_flags", rd_flags, e.flags);
        end
      end
    end else if (rd_valid !== 1'b0) begin
      fail_event("rd_valid rose without a matching read");
    end else if (rd_err !== 1'b0) begin
      fail_event("rd_err is set outside a read result");
    end
    if (ev_exp_q.size() > 0 && ev_exp_q[0].due == cyc) begin
      f = ev_exp_q.pop_front();
      compare("evict_en", evict_en, f.en);
      if (f.en && evict_en === 1'b1) begin
        compare("evict_addr", evict_addr, f.addr);
      end
    end else if (evict_en !== 1'b0) begin
      fail_event("evict_en rose without a fill");
    end
  endtask

  task automatic check_init();
    if (init_busy === 1'b1) begin
      if (init_over) begin
        fail_event("init_busy rose again after the sweep");
      end
      busy_cycles++;
    end else if (!init_over) begin
      init_over = 1'b1;
      compare("init_busy cycles", busy_cycles, `ICACHE_SETS);
    end
  endtask

  task automatic record_requests();
    req_t r;
    r.due  = cyc + 2;
    r.addr = rd_addr;
    r.flag = rd_set_flag;
    r.data = '0;
    if (rd_en === 1'b1) begin
      r.is_fill = 1'b0;
      req_q.push_back(r);
    end
    if (wr_en === 1'b1) begin
      r.is_fill = 1'b1;
      r.addr    = wr_addr;
      r.flag    = 1'b0;
      r.data    = wr_data;
      req_q.push_back(r);
    end
  endtask

  task automatic report_test();
    int errs;
    int checks;
    errs   = err_count - errs_before;
    checks = check_count - checks_before;
    $display("test %0d %-16s %0d checks, %0d errors: %s", test_id, test_name(test_id),
             checks, errs, (errs == 0) ? "ok" : "failing");
    errs_before   = err_count;
    checks_before = check_count;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      cyc         = 0;
      busy_cycles = 0;
      init_over   = 1'b0;
      req_q.delete();
      rd_exp_q.delete();
      ev_exp_q.delete();
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          m_valid[s][w] = 1'b0;
          m_used[s][w]  = 1'b0;
        end
      end
    end else begin
      cyc++;
      check_init();
      check_outputs();
      while (req_q.size() > 0 && req_q[0].due == cyc) begin
        if (req_q[0].is_fill) begin
          apply_fill(req_q[0]);
        end else begin
          apply_read(req_q[0]);
        end
        void'(req_q.pop_front());
      end
      if (init_busy === 1'b0) begin
        record_requests(); // the DUT drops everything during the sweep
      end
      if (test_done) begin
        report_test();
      end
    end
    idle <= (req_q.size() == 0) && (rd_exp_q.size() == 0) && (ev_exp_q.size() == 0);
  end

endmodule

/* sim/icache_tb.sv */
`include "icache_consts.svh"

module icache_tb import icache_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED = 32'heb50;
  localparam int NUM_TESTS = 5;
  localparam int T1_READS  = 16;
  localparam int T2_OPS    = 24;
  localparam int T3_LINES  = 3;
  localparam int T3_READS  = 8;
  localparam int T4_OPS    = 48;
  localparam int T5_OPS    = 12;
  localparam int RUN_CYCLES = 2 + `ICACHE_SETS + 1 + T1_READS + 3 * T2_OPS
                              + T3_LINES * (T3_READS + 5) + 2 * T4_OPS + 5 * T5_OPS
                              + 8 * NUM_TESTS;
  localparam int TIMEOUT_NS = RUN_CYCLES * 100 * 3 / 2;

  localparam logic [`ICACHE_TAG_BITS-1:0] TAG_BASE   = 'h2a000;
  localparam set_idx_t                    SET_BASE   = 7'h12;
  localparam set_idx_t                    VICTIM_SET = 7'h40;

  logic        clk;
  logic        rst;
  logic        rd_en;
  fetch_addr_t rd_addr;
  logic        rd_set_flag;
  logic        rd_valid;
  logic        rd_hit;
  line_t       rd_data;
  flags_t      rd_flags;
  logic        rd_err;
  logic        wr_en;
  fetch_addr_t wr_addr;
  line_t       wr_data;
  logic        init_busy;
  logic        evict_en;
  fetch_addr_t evict_addr;
  int          test_id;
  logic        test_done;
  logic        chk_idle;
  int          err_count;
  int          check_count;
  logic [31:0] lfsr_state;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  icache_top i_icache_top (
    .clk         (clk),
    .rst         (rst),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_set_flag (rd_set_flag),
    .rd_valid    (rd_valid),
    .rd_hit      (rd_hit),
    .rd_data     (rd_data),
    .rd_flags    (rd_flags),
    .rd_err      (rd_err),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .init_busy   (init_busy),
    .evict_en    (evict_en),
    .evict_addr  (evict_addr)
  );

  icache_checker i_checker (
    .idle (chk_idle),
    .*
  );

  // fibonacci LFSR over 32 bits with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic line_t rand_line();
    line_t d;
    d = '0;
    for (int i = 0; i < 4; i++) begin
      d = {d[95:0], rand_bits(32)};
    end
    return d;
  endfunction

  // eight tags over two sets keep the four ways busy with refills and evictions
  function automatic fetch_addr_t pool_addr();
    fetch_addr_t a;
    a.tag   = TAG_BASE + 3'(rand_bits(3));
    a.set   = SET_BASE + 1'(rand_bits(1));
    a.chunk = 4'(rand_bits(4));
    return a;
  endfunction

  task automatic do_read(input fetch_addr_t a, input logic set_flag);
    rd_en       = 1'b1;
    rd_addr     = a;
    rd_set_flag = set_flag;
    @(posedge clk);
    #10;
    rd_en       = 1'b0;
    rd_set_flag = 1'b0;
  endtask

  task automatic do_fill(input fetch_addr_t a, input line_t d);
    wr_en   = 1'b1;
    wr_addr = a;
    wr_data = d;
    @(posedge clk);
    #10;
    wr_en = 1'b0;
    @(posedge clk); // the host leaves a gap after every fill
    #10;
  endtask

  task automatic end_test();
    @(posedge clk);
    #10;
    while (!chk_idle) begin
      @(posedge clk);
      #10;
    end
    test_done = 1'b1;
    @(posedge clk);
    #10;
    test_done = 1'b0;
  endtask

  initial begin
    fetch_addr_t a;
    rst         = 1'b1;
    rd_en       = 1'b0;
    rd_addr     = '0;
    rd_set_flag = 1'b0;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    test_id     = 0;
    test_done   = 1'b0;
    lfsr_state  = SEED;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;

    test_id = 1;
    do_read(pool_addr(), 1'b0); // lands inside the sweep and must vanish
    while (init_busy) begin
      @(posedge clk);
      #10;
    end
    repeat (T1_READS) do_read(pool_addr(), lfsr_bit());
    end_test();

    test_id = 2;
    repeat (T2_OPS) begin
      a = pool_addr();
      do_fill(a, rand_line());
      do_read(a, lfsr_bit());
    end
    end_test();

    test_id = 3;
    repeat (T3_LINES) begin
      a = pool_addr();
      do_fill(a, rand_line());
      repeat (T3_READS) begin
        a.chunk = 4'(rand_bits(4));
        do_read(a, 1'b1);
      end
      do_fill(a, rand_line());
      do_read(a, 1'b0);
    end
    end_test();

    test_id = 4;
    repeat (T4_OPS) begin
      a     = pool_addr();
      a.set = VICTIM_SET;
      if (lfsr_bit()) begin
        do_fill(a, rand_line());
      end else begin
        do_read(a, 1'b0);
      end
    end
    end_test();

    test_id = 5;
    repeat (T5_OPS) begin
      a = pool_addr();
      do_fill(a, rand_line());
      do_fill(a, rand_line());
      do_read(a, 1'b0);
    end
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* all.f */
+incdir+hw
hw/icache_pkg.sv
hw/cc_if.sv
hw/cc_ram.sv
hw/cc_tag_way.sv
hw/cc_lookup.sv
hw/cc_line_store.sv
hw/cc_way_select.sv
hw/icache_top.sv
sim/icache_checker.sv
sim/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - hw
    files:
      - hw/icache_pkg.sv
      - hw/cc_if.sv
      - hw/cc_ram.sv
      - hw/cc_tag_way.sv
      - hw/cc_lookup.sv
      - hw/cc_line_store.sv
      - hw/cc_way_select.sv
      - hw/icache_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/icache_checker.sv
      - sim/icache_tb.sv
